//--- logic/axi_slv_wr_params.svh
// Bus widths, buffer depths and write response codes of the AXI write slave
`ifndef AXI_SLV_WR_PARAMS_SVH
`define AXI_SLV_WR_PARAMS_SVH

// --------------------------------------
// AXI field widths
// --------------------------------------
`define AXI_DW 32
`define AXI_AW 16
`define AXI_IW 4
// Burst length field, beats minus one
`define AXI_LW 8
`define AXI_SW 3
`define AXI_BW 2
`define AXI_RW 2

// --------------------------------------
// Buffer depths
// --------------------------------------
// Outstanding write addresses
`define AW_DEPTH 4
// Buffered write data beats
`define W_DEPTH 16
// Pending write responses
`define B_DEPTH 4

// BRESP encodings in use; EXOKAY and DECERR never issued
`define RESP_OKAY 2'b00
`define RESP_SLVERR 2'b10

`endif

//--- logic/axi_slv_wr_pkg.sv
// Width typedefs, burst-type constants and burst phase enum of the AXI write slave
`default_nettype none

`include "axi_slv_wr_params.svh"

package axi_slv_wr_pkg;

    // --------------------------------------
    // Field types
    // --------------------------------------
    typedef logic [`AXI_DW-1:0]   axi_data_t;
    // One strobe bit per data byte
    typedef logic [`AXI_DW/8-1:0] axi_strb_t;
    typedef logic [`AXI_AW-1:0]   axi_addr_t;
    typedef logic [`AXI_IW-1:0]   axi_id_t;
    // Beats minus one
    typedef logic [`AXI_LW-1:0]   axi_len_t;
    // Log2 of bytes per beat
    typedef logic [`AXI_SW-1:0]   axi_size_t;
    typedef logic [`AXI_BW-1:0]   axi_burst_t;
    typedef logic [`AXI_RW-1:0]   axi_resp_t;

    // --------------------------------------
    // Burst encodings
    // --------------------------------------
    localparam axi_burst_t BURST_FIXED = 2'b00;
    localparam axi_burst_t BURST_INCR  = 2'b01;

    // Widest legal beat, log2 of the bus bytes
    localparam axi_size_t MAX_SIZE = axi_size_t'($clog2(`AXI_DW / 8));

    // Burst replay phases
    typedef enum logic [1:0] {
        PH_IDLE  = 2'b00,
        PH_FIRST = 2'b01,
        PH_BURST = 2'b10
    } burst_phase_e;

endpackage

`default_nettype wire

//--- logic/sync_fifo.sv
// Single-clock show-ahead FIFO with occupancy count and full and empty flags
`default_nettype none

module sync_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);

    // Pointer needs at least one bit even for a single entry
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_ok;
    logic             pop_ok;

    // Pointer advance with wrap at the last entry
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // --------------------------------------
    // Flags and head
    // --------------------------------------
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Push on full and pop on empty are dropped
    assign push_ok = push & ~full;
    assign pop_ok  = pop & ~empty;

    // Show-ahead, head word always on dout
    assign dout = mem[rd_ptr];

    // --------------------------------------
    // Storage
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/burst_addr_gen.sv
// Per-beat write address register with size alignment and FIXED or INCR stepping
`default_nettype none

module burst_addr_gen (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      step,
    input  axi_slv_wr_pkg::axi_addr_t  start_addr,
    input  axi_slv_wr_pkg::axi_size_t  size,
    input  axi_slv_wr_pkg::axi_burst_t burst,
    output axi_slv_wr_pkg::axi_addr_t  addr
);

    import axi_slv_wr_pkg::*;

    axi_addr_t beat_bytes;
    axi_addr_t align_mask;
    axi_addr_t incr;
    axi_addr_t aligned_addr;
    axi_addr_t addr_q;

    // --------------------------------------
    // Increment and alignment
    // --------------------------------------
    // Bytes moved per beat
    assign beat_bytes = axi_addr_t'(1) << size;

    // Clears the address bits below the beat size
    assign align_mask = {`AXI_AW{1'b1}} << size;

    assign aligned_addr = start_addr & align_mask;

    // FIXED stays put; WRAP and reserved codes step like INCR
    always_comb begin
        case (burst)
            BURST_FIXED: incr = '0;
            BURST_INCR:  incr = beat_bytes;
            default:     incr = beat_bytes;
        endcase
    end

    // --------------------------------------
    // Address register
    // --------------------------------------
    // Start loads the second beat address, each step moves one more beat
    // Carry out of the top bit is dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (start) begin
            addr_q <= aligned_addr + incr;
        end else if (step) begin
            addr_q <= addr_q + incr;
        end
    end

    // First beat goes out at the raw, possibly unaligned, start address
    assign addr = start ? start_addr : addr_q;

endmodule

`default_nettype wire

//--- logic/wr_burst_ctrl.sv
// Burst phase FSM, AW command latch, beat counter and B response generation
`default_nettype none

`include "axi_slv_wr_params.svh"

module wr_burst_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    // AW buffer head
    input  logic                       aw_empty,
    input  axi_slv_wr_pkg::axi_id_t     aq_id,
    input  axi_slv_wr_pkg::axi_addr_t   aq_addr,
    input  axi_slv_wr_pkg::axi_len_t    aq_len,
    input  axi_slv_wr_pkg::axi_size_t   aq_size,
    input  axi_slv_wr_pkg::axi_burst_t  aq_burst,
    output logic                       aw_pop,
    // W buffer head
    input  logic                       w_empty,
    input  axi_slv_wr_pkg::axi_data_t   wq_data,
    input  axi_slv_wr_pkg::axi_strb_t   wq_strb,
    output logic                       w_pop,
    // B buffer
    input  logic                       b_full,
    output logic                       b_push,
    output axi_slv_wr_pkg::axi_id_t     b_id,
    output axi_slv_wr_pkg::axi_resp_t   b_resp,
    // Address generator
    output logic                       addr_start,
    output logic                       addr_step,
    input  axi_slv_wr_pkg::axi_addr_t   cur_addr_in,
    output axi_slv_wr_pkg::axi_size_t   beat_size,
    output axi_slv_wr_pkg::axi_burst_t  beat_burst,
    // User write port
    output logic                       m_we,
    output axi_slv_wr_pkg::axi_addr_t   m_waddr,
    output axi_slv_wr_pkg::axi_data_t   m_wdata,
    output axi_slv_wr_pkg::axi_strb_t   m_wstrb,
    output axi_slv_wr_pkg::axi_size_t   m_wsize,
    output logic                       m_wlast
);

    import axi_slv_wr_pkg::*;

    burst_phase_e phase;
    burst_phase_e phase_nxt;

    // Latched command of the burst in flight
    axi_id_t    id_q;
    axi_len_t   len_q;
    axi_size_t  size_q;
    axi_burst_t burst_q;

    // Beats already written in this burst
    axi_len_t   beat_cnt;

    logic       in_first;
    logic       in_burst;
    logic       beat_last;
    logic       beat_avail;
    logic       beat_go;
    logic       first_go;
    logic       burst_go;

    // --------------------------------------
    // Beat qualification
    // --------------------------------------
    assign in_first = (phase == PH_FIRST);
    assign in_burst = (phase == PH_BURST);

    // Head fields drive the first beat, latched ones the rest
    assign beat_last  = in_first ? (aq_len == '0) : (beat_cnt == len_q);
    assign beat_size  = in_first ? aq_size : size_q;
    assign beat_burst = in_first ? aq_burst : burst_q;

    // First beat needs the command and its data together
    assign beat_avail = (in_first & ~aw_empty & ~w_empty) | (in_burst & ~w_empty);

    // Last beat waits for a free response slot
    assign beat_go  = beat_avail & (~beat_last | ~b_full);
    assign first_go = beat_go & in_first;
    assign burst_go = beat_go & in_burst;

    // --------------------------------------
    // Buffer and generator strobes
    // --------------------------------------
    assign aw_pop     = first_go;
    assign w_pop      = beat_go;
    assign addr_start = first_go;
    assign addr_step  = burst_go;

    // Response leaves with the last beat
    assign b_push = beat_go & beat_last;
    assign b_id   = in_first ? aq_id : id_q;
    assign b_resp = (beat_size > MAX_SIZE) ? axi_resp_t'(`RESP_SLVERR)
                                           : axi_resp_t'(`RESP_OKAY);

    // User port
    assign m_we    = beat_go;
    assign m_waddr = cur_addr_in;
    assign m_wdata = wq_data;
    assign m_wstrb = wq_strb;
    assign m_wsize = beat_size;
    assign m_wlast = beat_go & beat_last;

    // --------------------------------------
    // Phase FSM
    // --------------------------------------
    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_IDLE: phase_nxt = PH_FIRST;
            // Single-beat bursts never leave PH_FIRST
            PH_FIRST: begin
                if (first_go && !beat_last) begin
                    phase_nxt = PH_BURST;
                end
            end
            PH_BURST: begin
                if (burst_go && beat_last) begin
                    phase_nxt = PH_FIRST;
                end
            end
            default: phase_nxt = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_IDLE;
        end else begin
            phase <= phase_nxt;
        end
    end

    // Beat counter reads one after the first beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (first_go) begin
            beat_cnt <= axi_len_t'(1);
        end else if (burst_go) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // Command latch on AW pop
    always_ff @(posedge clk) begin
        if (aw_pop) begin
            id_q    <= aq_id;
            len_q   <= aq_len;
            size_q  <= aq_size;
            burst_q <= aq_burst;
        end
    end

endmodule

`default_nettype wire

//--- logic/axi_slv_wr.sv
// AXI4 write slave top with AW, W and B buffers, burst controller and address generator
`default_nettype none

`include "axi_slv_wr_params.svh"

module axi_slv_wr (
    input  logic                       clk,
    input  logic                       rst_n,
    // AW channel
    input  axi_slv_wr_pkg::axi_id_t     awid,
    input  axi_slv_wr_pkg::axi_addr_t   awaddr,
    input  axi_slv_wr_pkg::axi_len_t    awlen,
    input  axi_slv_wr_pkg::axi_size_t   awsize,
    input  axi_slv_wr_pkg::axi_burst_t  awburst,
    input  logic                       awvalid,
    output logic                       awready,
    // W channel
    input  axi_slv_wr_pkg::axi_data_t   wdata,
    input  axi_slv_wr_pkg::axi_strb_t   wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    // B channel
    output axi_slv_wr_pkg::axi_id_t     bid,
    output axi_slv_wr_pkg::axi_resp_t   bresp,
    output logic                       bvalid,
    input  logic                       bready,
    // User write port
    output logic                       m_we,
    output axi_slv_wr_pkg::axi_addr_t   m_waddr,
    output axi_slv_wr_pkg::axi_data_t   m_wdata,
    output axi_slv_wr_pkg::axi_strb_t   m_wstrb,
    output axi_slv_wr_pkg::axi_size_t   m_wsize,
    output logic                       m_wlast
);

    import axi_slv_wr_pkg::*;

    // Buffer word widths
    localparam int AW_WORD_W = `AXI_IW + `AXI_AW + `AXI_LW + `AXI_SW + `AXI_BW;
    localparam int W_WORD_W  = `AXI_DW + `AXI_DW / 8;
    localparam int B_WORD_W  = `AXI_IW + `AXI_RW;

    // AW buffer
    logic                 aw_push;
    logic                 aw_pop;
    logic                 aw_full;
    logic                 aw_empty;
    logic [AW_WORD_W-1:0] aw_dout;
    axi_id_t              aq_id;
    axi_addr_t            aq_addr;
    axi_len_t             aq_len;
    axi_size_t            aq_size;
    axi_burst_t           aq_burst;

    // W buffer
    logic                 w_push;
    logic                 w_pop;
    logic                 w_full;
    logic                 w_empty;
    logic [W_WORD_W-1:0]  w_dout;
    axi_data_t            wq_data;
    axi_strb_t            wq_strb;

    // B buffer
    logic                 b_push;
    logic                 b_pop;
    logic                 b_full;
    logic                 b_empty;
    logic [B_WORD_W-1:0]  b_dout;
    axi_id_t              b_id;
    axi_resp_t            b_resp;

    // Address generator link
    logic                 addr_start;
    logic                 addr_step;
    axi_addr_t            cur_addr;
    axi_size_t            beat_size;
    axi_burst_t           beat_burst;

    // --------------------------------------
    // AXI handshakes
    // --------------------------------------
    assign awready = ~aw_full;
    assign wready  = ~w_full;
    assign bvalid  = ~b_empty;

    assign aw_push = awvalid & awready;
    assign w_push  = wvalid & wready;
    assign b_pop   = bvalid & bready;

    // Head word unpacking
    assign {aq_id, aq_addr, aq_len, aq_size, aq_burst} = aw_dout;
    assign {wq_data, wq_strb} = w_dout;
    assign {bid, bresp} = b_dout;

    // --------------------------------------
    // Channel buffers
    // --------------------------------------
    sync_fifo #(.DEPTH(`AW_DEPTH), .WIDTH(AW_WORD_W)) aw_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (aw_push),
        .din   ({awid, awaddr, awlen, awsize, awburst}),
        .pop   (aw_pop),
        .dout  (aw_dout),
        .full  (aw_full),
        .empty (aw_empty)
    );

    sync_fifo #(.DEPTH(`W_DEPTH), .WIDTH(W_WORD_W)) w_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (w_push),
        .din   ({wdata, wstrb}),
        .pop   (w_pop),
        .dout  (w_dout),
        .full  (w_full),
        .empty (w_empty)
    );

    sync_fifo #(.DEPTH(`B_DEPTH), .WIDTH(B_WORD_W)) b_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (b_push),
        .din   ({b_id, b_resp}),
        .pop   (b_pop),
        .dout  (b_dout),
        .full  (b_full),
        .empty (b_empty)
    );

    // --------------------------------------
    // Burst replay
    // --------------------------------------
    wr_burst_ctrl i_wr_burst_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .aw_empty    (aw_empty),
        .aq_id       (aq_id),
        .aq_addr     (aq_addr),
        .aq_len      (aq_len),
        .aq_size     (aq_size),
        .aq_burst    (aq_burst),
        .aw_pop      (aw_pop),
        .w_empty     (w_empty),
        .wq_data     (wq_data),
        .wq_strb     (wq_strb),
        .w_pop       (w_pop),
        .b_full      (b_full),
        .b_push      (b_push),
        .b_id        (b_id),
        .b_resp      (b_resp),
        .addr_start  (addr_start),
        .addr_step   (addr_step),
        .cur_addr_in (cur_addr),
        .beat_size   (beat_size),
        .beat_burst  (beat_burst),
        .m_we        (m_we),
        .m_waddr     (m_waddr),
        .m_wdata     (m_wdata),
        .m_wstrb     (m_wstrb),
        .m_wsize     (m_wsize),
        .m_wlast     (m_wlast)
    );

    // Start address taken straight from the AW head
    burst_addr_gen i_burst_addr_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (addr_start),
        .step       (addr_step),
        .start_addr (aq_addr),
        .size       (beat_size),
        .burst      (beat_burst),
        .addr       (cur_addr)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// Testbench clock of period 8 and active-low reset held for 8 cycles
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/axi_slv_wr_checker.sv
// Bound concurrent assertions on reset values, response timing and B channel stability
`default_nettype none

`include "axi_slv_wr_params.svh"

module axi_slv_wr_checker (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      m_we,
    input logic                      m_wlast,
    input logic                      awready,
    input logic                      wready,
    input logic                      bvalid,
    input logic                      bready,
    input axi_slv_wr_pkg::axi_id_t   bid,
    input axi_slv_wr_pkg::axi_resp_t bresp
);

    import axi_slv_wr_pkg::*;

    // Failed assertions so far
    int fail_cnt = 0;

    // --------------------------------------
    // Reset behavior
    // --------------------------------------
    reset_idle: assert property (@(posedge clk)
        !rst_n |-> (!m_we && !bvalid && awready && wready))
        else begin
            fail_cnt++;
            $error("outputs not idle while in reset");
        end

    // First cycle out of reset
    reset_exit: assert property (@(posedge clk)
        $rose(rst_n) |-> (!m_we && !bvalid && awready && wready))
        else begin
            fail_cnt++;
            $error("outputs not idle right after reset");
        end

    // --------------------------------------
    // User port and B channel
    // --------------------------------------
    // Last beat into an empty response buffer shows up one cycle later
    resp_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        (m_we && m_wlast && !bvalid) |=> bvalid)
        else begin
            fail_cnt++;
            $error("no write response one cycle after the last beat");
        end

    // Pending response holds until taken
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (bvalid && !bready) |=> (bvalid && $stable(bid) && $stable(bresp)))
        else begin
            fail_cnt++;
            $error("write response dropped or changed before bready");
        end

    b_legal: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid |-> (bresp == axi_resp_t'(`RESP_OKAY) || bresp == axi_resp_t'(`RESP_SLVERR)))
        else begin
            fail_cnt++;
            $error("write response code is EXOKAY or DECERR");
        end

endmodule

`default_nettype wire

//--- verification/axi_slv_wr_tb.sv
// Testbench of the AXI4 write slave with LFSR stimulus, beat and response model and report
`default_nettype none

`include "axi_slv_wr_params.svh"

module axi_slv_wr_tb;

    import axi_slv_wr_pkg::*;

    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 400;

    // Test kinds
    localparam int KIND_ALIGNED      = 0;
    localparam int KIND_NARROW       = 1;
    localparam int KIND_FIXED        = 2;
    localparam int KIND_OVERSIZE     = 3;
    localparam int KIND_BACKPRESSURE = 4;

    logic       clk;
    logic       rst_n;
    axi_id_t    awid;
    axi_addr_t  awaddr;
    axi_len_t   awlen;
    axi_size_t  awsize;
    axi_burst_t awburst;
    logic       awvalid;
    logic       awready;
    axi_data_t  wdata;
    axi_strb_t  wstrb;
    logic       wvalid;
    logic       wready;
    axi_id_t    bid;
    axi_resp_t  bresp;
    logic       bvalid;
    logic       bready;
    logic       m_we;
    axi_addr_t  m_waddr;
    axi_data_t  m_wdata;
    axi_strb_t  m_wstrb;
    axi_size_t  m_wsize;
    logic       m_wlast;

    // Stimulus waiting to be driven
    axi_id_t    cmd_id_q[$];
    axi_addr_t  cmd_addr_q[$];
    axi_len_t   cmd_len_q[$];
    axi_size_t  cmd_size_q[$];
    axi_burst_t cmd_burst_q[$];
    int         aw_gap_q[$];
    axi_data_t  dat_q[$];
    axi_strb_t  strb_q[$];
    int         w_gap_q[$];

    // Expected user beats and responses, in order
    axi_addr_t  exp_addr_q[$];
    axi_data_t  exp_data_q[$];
    axi_strb_t  exp_strb_q[$];
    axi_size_t  exp_size_q[$];
    logic       exp_last_q[$];
    axi_id_t    exp_bid_q[$];
    axi_resp_t  exp_bresp_q[$];

    logic [31:0] lfsr_q = 32'h70bc1103;
    int          errors = 0;
    int          checks = 0;
    int          beats_seen = 0;
    int          resps_seen = 0;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    axi_slv_wr i_axi_slv_wr (
        .clk     (clk),
        .rst_n   (rst_n),
        .awid    (awid),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awsize  (awsize),
        .awburst (awburst),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bid     (bid),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .m_we    (m_we),
        .m_waddr (m_waddr),
        .m_wdata (m_wdata),
        .m_wstrb (m_wstrb),
        .m_wsize (m_wsize),
        .m_wlast (m_wlast)
    );

    bind axi_slv_wr axi_slv_wr_checker i_checker (
        .clk     (clk),
        .rst_n   (rst_n),
        .m_we    (m_we),
        .m_wlast (m_wlast),
        .awready (awready),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .bid     (bid),
        .bresp   (bresp)
    );

    // --------------------------------------
    // Random source
    // --------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic int error_total();
        return errors + i_axi_slv_wr.i_checker.fail_cnt;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // --------------------------------------
    // Burst generation and reference model
    // --------------------------------------
    task automatic make_burst(input int kind);
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
        axi_addr_t  aligned;
        axi_addr_t  incr;
        axi_data_t  data;
        axi_strb_t  strb;
        id   = axi_id_t'(rand_bits(4));
        addr = axi_addr_t'(rand_bits(16));
        len  = axi_len_t'(rand_bits(3));
        case (kind)
            KIND_ALIGNED: begin
                size      = axi_size_t'(2);
                burst     = BURST_INCR;
                addr[1:0] = 2'b00;
            end
            KIND_NARROW: begin
                size  = axi_size_t'(rand_bits(2) % 3);
                burst = BURST_INCR;
            end
            KIND_FIXED: begin
                size  = axi_size_t'(rand_bits(2) % 3);
                burst = BURST_FIXED;
            end
            KIND_OVERSIZE: begin
                size  = axi_size_t'(3 + rand_bits(2));
                burst = rand_bits(1) ? BURST_INCR : BURST_FIXED;
            end
            default: begin
                // Longer mixed bursts to fill every buffer
                size  = axi_size_t'(rand_bits(2) % 3);
                burst = rand_bits(1) ? BURST_INCR : BURST_FIXED;
                len   = axi_len_t'(rand_bits(4));
            end
        endcase
        // Base with bits below the size cleared, step of 2**size unless FIXED
        aligned = (addr >> size) << size;
        incr    = (burst == BURST_FIXED) ? axi_addr_t'(0) : (axi_addr_t'(1) << size);
        cmd_id_q.push_back(id);
        cmd_addr_q.push_back(addr);
        cmd_len_q.push_back(len);
        cmd_size_q.push_back(size);
        cmd_burst_q.push_back(burst);
        aw_gap_q.push_back(int'(rand_bits(2)));
        exp_bid_q.push_back(id);
        exp_bresp_q.push_back((size > axi_size_t'(2)) ? axi_resp_t'(`RESP_SLVERR)
                                                      : axi_resp_t'(`RESP_OKAY));
        for (int i = 0; i <= int'(len); i++) begin
            data = axi_data_t'(rand_bits(32));
            strb = axi_strb_t'(rand_bits(4));
            dat_q.push_back(data);
            strb_q.push_back(strb);
            w_gap_q.push_back(int'(rand_bits(1)));
            // First beat keeps the raw start address
            exp_addr_q.push_back((i == 0) ? addr : axi_addr_t'(aligned + axi_addr_t'(i) * incr));
            exp_data_q.push_back(data);
            exp_strb_q.push_back(strb);
            exp_size_q.push_back(size);
            exp_last_q.push_back(i == int'(len));
        end
    endtask

    // --------------------------------------
    // Channel drivers
    // --------------------------------------
    task automatic issue_addresses();
        int   gap;
        logic seen;
        while (cmd_id_q.size() > 0) begin
            gap = aw_gap_q.pop_front();
            if (gap > 0) begin
                awvalid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            awid    <= cmd_id_q.pop_front();
            awaddr  <= cmd_addr_q.pop_front();
            awlen   <= cmd_len_q.pop_front();
            awsize  <= cmd_size_q.pop_front();
            awburst <= cmd_burst_q.pop_front();
            awvalid <= 1'b1;
            // Ready sampled mid-cycle, transfer on the next rising edge
            do begin
                @(negedge clk);
                seen = awready;
                @(posedge clk);
            end while (!seen);
        end
        awvalid <= 1'b0;
    endtask

    task automatic stream_data();
        int   gap;
        logic seen;
        while (dat_q.size() > 0) begin
            gap = w_gap_q.pop_front();
            if (gap > 0) begin
                wvalid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            wdata  <= dat_q.pop_front();
            wstrb  <= strb_q.pop_front();
            wvalid <= 1'b1;
            do begin
                @(negedge clk);
                seen = wready;
                @(posedge clk);
            end while (!seen);
        end
        wvalid <= 1'b0;
    endtask

    // Runs until every expected beat and response has been seen
    task automatic run_test(input int kind, input int bursts, input string name);
        int err_start;
        int hold;
        err_start = error_total();
        for (int b = 0; b < bursts; b++) begin
            make_burst(kind);
        end
        hold = (kind == KIND_BACKPRESSURE) ? 80 : 0;
        @(posedge clk);
        fork
            issue_addresses();
            stream_data();
        join_none
        while (exp_addr_q.size() > 0 || exp_bid_q.size() > 0) begin
            if (hold > 0) begin
                bready <= 1'b0;
                hold--;
            end else begin
                bready <= (rand_bits(2) != 0);
            end
            @(posedge clk);
        end
        $display("test %s: %0d bursts, %0d errors", name, bursts, error_total() - err_start);
    endtask

    // --------------------------------------
    // Monitors
    // --------------------------------------
    // A strobe seen between edges is a beat taken at the next rising edge
    always @(negedge clk) begin : beat_monitor
        if (rst_n && m_we) begin
            beats_seen++;
            if (exp_addr_q.size() == 0) begin
                errors++;
                $display("write beat at time %0t with no burst outstanding", $time);
            end else begin
                check_value("m_waddr", 32'(exp_addr_q.pop_front()), 32'(m_waddr));
                check_value("m_wdata", exp_data_q.pop_front(), m_wdata);
                check_value("m_wstrb", 32'(exp_strb_q.pop_front()), 32'(m_wstrb));
                check_value("m_wsize", 32'(exp_size_q.pop_front()), 32'(m_wsize));
                check_value("m_wlast", 32'(exp_last_q.pop_front()), 32'(m_wlast));
            end
        end
    end

    always @(negedge clk) begin : resp_monitor
        if (rst_n && bvalid && bready) begin
            resps_seen++;
            if (exp_bid_q.size() == 0) begin
                errors++;
                $display("write response at time %0t with no burst outstanding", $time);
            end else begin
                check_value("bid", 32'(exp_bid_q.pop_front()), 32'(bid));
                check_value("bresp", 32'(exp_bresp_q.pop_front()), 32'(bresp));
            end
        end
    end

    // --------------------------------------
    // Sequence and report
    // --------------------------------------
    initial begin : main
        int total;
        awid    = '0;
        awaddr  = '0;
        awlen   = '0;
        awsize  = '0;
        awburst = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        wait (rst_n === 1'b1);
        repeat (4) @(posedge clk);
        run_test(KIND_ALIGNED, 6, "aligned INCR full size");
        run_test(KIND_NARROW, 6, "narrow unaligned INCR");
        run_test(KIND_FIXED, 6, "FIXED");
        run_test(KIND_OVERSIZE, 6, "size above bus width");
        run_test(KIND_BACKPRESSURE, 10, "bready held low");
        // Room for stray beats or responses
        repeat (20) @(posedge clk);
        total = error_total();
        $display("%0d tests, %0d beats, %0d responses, %0d checks, %0d errors",
                 NUM_TESTS, beats_seen, resps_seen, checks, total);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- axi_slv_wr.f
+incdir+logic
logic/axi_slv_wr_pkg.sv
logic/sync_fifo.sv
logic/burst_addr_gen.sv
logic/wr_burst_ctrl.sv
logic/axi_slv_wr.sv
verification/tb_clock_gen.sv
verification/axi_slv_wr_checker.sv
verification/axi_slv_wr_tb.sv

//--- Makefile
# Verilator lint and simulation of the AXI4 write slave

TOP := axi_slv_wr_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module axi_slv_wr -f axi_slv_wr.f
	verilator --lint-only --timing --assert --top-module $(TOP) -f axi_slv_wr.f

# The run's own status is ignored, the log decides pass or fail
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f axi_slv_wr.f
	-./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1
	@cat sim.log
	@grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
